/* all.f */
+incdir+include
hw/bfly_pkg.sv
hw/mont_mul_lanes.sv
hw/mod_add_sub_lanes.sv
hw/out_buffer.sv
hw/ntt_butterfly.sv
tb/ntt_butterfly_props.sv
tb/tb_ntt_butterfly.sv

/* run.sh */
#!/bin/sh
# build and run the butterfly testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_ntt_butterfly -f all.f \
    -o sim_bfly > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_bfly > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

/* tb/tb_ntt_butterfly.sv */
`include "bfly_settings.svh"

module tb_ntt_butterfly;
    import bfly_pkg::*;

    localparam int WAIT_LIMIT  = 200;    // cycles for one handshake
    localparam int DRAIN_LIMIT = 4000;

    logic   clk;
    logic   rst_n;
    logic   i_vld;
    logic   i_rdy;
    word_t  i_a;
    word_t  i_b;
    word_t  i_w;
    logic   o_vld;
    logic   o_rdy;
    word_t  o_ao;
    word_t  o_bo;
    integer seed;
    int     r_inv;         // R^-1 mod q
    int     sink_mode;     // 0 ready, 1 random, 2 stalled
    int     value_errs;
    int     other_errs;
    word_t  exp_ao_q [$];
    word_t  exp_bo_q [$];

    ntt_butterfly i_dut (
        .clk(clk), .rst_n(rst_n), .i_vld(i_vld), .i_rdy(i_rdy),
        .i_a(i_a), .i_b(i_b), .i_w(i_w),
        .o_vld(o_vld), .o_rdy(o_rdy), .o_ao(o_ao), .o_bo(o_bo)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // a +/- b*w*R^-1 per lane, plain modular arithmetic
    function automatic void butterfly_ref(input word_t a, input word_t b, input word_t w,
                                          output word_t ao, output word_t bo);
        prod_t  p;
        longint t;
        longint av;
        for (int l = 0; l < `BFLY_LANES; l++) begin
            p  = prod_t'(b[l]) * prod_t'(w[l]);
            t  = (longint'(p) % `BFLY_Q) * r_inv % `BFLY_Q;
            av = longint'(a[l]);
            ao[l] = coef_t'((av + t) % `BFLY_Q);
            bo[l] = coef_t'((av - t + `BFLY_Q) % `BFLY_Q);
        end
    endfunction

    function automatic word_t rand_word();
        word_t x;
        for (int l = 0; l < `BFLY_LANES; l++) begin
            x[l] = coef_t'($unsigned($random(seed)) % `BFLY_Q);
        end
        return x;
    endfunction

    task automatic find_constants();
        longint x;
        longint mask;
        mask = (longint'(1) << `BFLY_COEF_W) - 1;
        x = 1;
        while (((x << `BFLY_COEF_W) % `BFLY_Q) != 1 && x < `BFLY_Q) begin
            x++;
        end
        r_inv = int'(x);
        x = 0;
        while (((x * `BFLY_Q) & mask) != mask && x <= mask) begin   // q*x == -1 mod R
            x++;
        end
        assert (x == `BFLY_QINV_NEG) else begin
            value_errs++;
            $display("FAIL t=%0t BFLY_QINV_NEG expected %0d got %0d",
                     $time, x, `BFLY_QINV_NEG);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            value_errs++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        assert (got === exp) else begin
            value_errs++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic finish_run();
        $display("errors: value=%0d other=%0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string why);
        other_errs++;
        $display("timeout: %s", why);
        finish_run();
    endtask

    // expectation is formed from what the DUT takes on this edge
    always @(posedge clk) begin
        word_t ao;
        word_t bo;
        if (rst_n && i_vld && i_rdy) begin
            butterfly_ref(i_a, i_b, i_w, ao, bo);
            exp_ao_q.push_back(ao);
            exp_bo_q.push_back(bo);
        end
    end

    always @(posedge clk) begin
        if (rst_n && o_vld && o_rdy) begin
            assert (exp_ao_q.size() > 0) else begin
                other_errs++;
                $display("output transfer at %0t with no word outstanding", $time);
            end
            if (exp_ao_q.size() > 0) begin
                check_word("o_ao", exp_ao_q.pop_front(), o_ao);
                check_word("o_bo", exp_bo_q.pop_front(), o_bo);
            end
        end
    end

    always @(posedge clk) begin
        if (sink_mode == 1) begin
            o_rdy <= ($random(seed) & 1) != 0;
        end else begin
            o_rdy <= (sink_mode == 0);
        end
    end

    task automatic send_word(input word_t a, input word_t b, input word_t w);
        int cycles;
        cycles = 0;
        i_vld <= 1'b1;
        i_a   <= a;
        i_b   <= b;
        i_w   <= w;
        @(posedge clk);
        while (!i_rdy && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge clk);
        end
        i_vld <= 1'b0;   // next send overrides at the same edge
        if (!i_rdy) begin
            give_up("i_rdy stayed low while sending a word");
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_ao_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            cycles++;
            @(negedge clk);   // away from the compare edge
        end
        @(posedge clk);
        if (exp_ao_q.size() != 0) begin
            give_up("results still outstanding at the end of a drain");
        end
    endtask

    task automatic apply_reset();
        i_vld <= 1'b0;
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        exp_ao_q.delete();
        exp_bo_q.delete();
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("o_vld", 1'b0, o_vld);
        check_bit("i_rdy", 1'b1, i_rdy);
    endtask

    task automatic directed_cases();
        word_t a;
        word_t b;
        word_t w;
        int    pb [`BFLY_LANES] = '{1, 2, 3, 111, `BFLY_Q - 1, 1, 2, 110};
        int    pw [`BFLY_LANES] = '{`BFLY_Q - 1, 6144, 4096, 111, `BFLY_Q - 1, 1, 6145, 112};
        send_word('0, '0, '0);
        send_word(rand_word(), rand_word(), {`BFLY_LANES{coef_t'(1)}});
        a = {`BFLY_LANES{coef_t'(`BFLY_Q - 1)}};
        send_word(a, '0, rand_word());
        for (int l = 0; l < `BFLY_LANES; l++) begin
            b[l] = coef_t'(pb[l]);    // b*w lands on or near q
            w[l] = coef_t'(pw[l]);
        end
        send_word(a, b, w);
        send_word('0, b, w);          // subtract wraps below zero
        wait_drain();
    endtask

    // stall the sink until i_rdy drops, then let it all out
    task automatic stall_fill();
        int accepted;
        accepted = 0;
        sink_mode = 2;
        o_rdy <= 1'b0;
        i_vld <= 1'b1;
        i_a   <= rand_word();
        i_b   <= rand_word();
        i_w   <= rand_word();
        @(posedge clk);
        while (i_rdy && accepted < WAIT_LIMIT) begin
            accepted++;
            i_a <= rand_word();
            i_b <= rand_word();
            i_w <= rand_word();
            @(posedge clk);
        end
        i_vld <= 1'b0;
        assert (!i_rdy) else begin
            other_errs++;
            $display("i_rdy never dropped while the output was stalled");
        end
        assert (accepted <= `BFLY_BUF_DEPTH) else begin
            value_errs++;
            $display("FAIL t=%0t accepted words expected <= %0d got %0d",
                     $time, `BFLY_BUF_DEPTH, accepted);
        end
        repeat (30) @(posedge clk);
        sink_mode = 0;
        wait_drain();
    endtask

    initial begin
        seed       = 32'hcced;
        value_errs = 0;
        other_errs = 0;
        sink_mode  = 0;
        rst_n      = 1'b0;
        i_vld      = 1'b0;
        i_a        = '0;
        i_b        = '0;
        i_w        = '0;
        o_rdy      = 1'b0;
        find_constants();
        apply_reset();

        directed_cases();
        repeat (500) send_word(rand_word(), rand_word(), rand_word());
        wait_drain();

        sink_mode = 1;
        repeat (300) send_word(rand_word(), rand_word(), rand_word());
        sink_mode = 0;
        wait_drain();

        stall_fill();

        // reset with results still in the pipe and the FIFO
        sink_mode = 1;
        repeat (20) send_word(rand_word(), rand_word(), rand_word());
        apply_reset();
        repeat (100) send_word(rand_word(), rand_word(), rand_word());
        sink_mode = 0;
        wait_drain();
        finish_run();
    end

endmodule

/* tb/ntt_butterfly_props.sv */
`include "bfly_settings.svh"

module ntt_butterfly_props (
    input logic            clk,
    input logic            rst_n,
    input logic            i_rdy,
    input logic            accept,
    input logic            o_vld,
    input logic            o_rdy,
    input bfly_pkg::word_t o_ao,
    input bfly_pkg::word_t o_bo
);
    import bfly_pkg::*;

    int owed;   // accepted words not yet taken at the output

    function automatic logic lanes_below_q(word_t x);
        for (int l = 0; l < `BFLY_LANES; l++) begin
            if (x[l] >= coef_t'(`BFLY_Q)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owed <= 0;
        end else begin
            owed <= owed + int'(accept) - int'(o_vld && o_rdy);
        end
    end

    // a waiting result is held until the sink takes it
    vld_held: assert property (@(posedge clk) disable iff (!rst_n)
        o_vld && !o_rdy |=> o_vld)
        else $error("o_vld dropped before the result was taken");

    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        o_vld && !o_rdy |=> $stable(o_ao) && $stable(o_bo))
        else $error("output data changed while stalled");

    lanes_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        o_vld |-> lanes_below_q(o_ao) && lanes_below_q(o_bo))
        else $error("output lane at or above q");

    // no room left once every slot is owed to an accepted word
    no_accept_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        owed >= `BFLY_BUF_DEPTH |-> !i_rdy)
        else $error("i_rdy high with every buffer slot already owed");

endmodule

bind ntt_butterfly ntt_butterfly_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_rdy  (i_rdy),
    .accept (accept),
    .o_vld  (o_vld),
    .o_rdy  (o_rdy),
    .o_ao   (o_ao),
    .o_bo   (o_bo)
);

/* hw/ntt_butterfly.sv */
module ntt_butterfly (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_vld,
    output logic            i_rdy,
    input  bfly_pkg::word_t i_a,
    input  bfly_pkg::word_t i_b,
    input  bfly_pkg::word_t i_w,
    output logic            o_vld,
    input  logic            o_rdy,
    output bfly_pkg::word_t o_ao,
    output bfly_pkg::word_t o_bo
);
    import bfly_pkg::*;

    logic  accept;    // word taken on this edge
    logic  mul_vld;
    word_t mul_a;     // a delayed to line up with the product
    word_t mul_prod;
    logic  res_vld;
    word_t res_ao;
    word_t res_bo;

    assign accept = i_vld & i_rdy;

    // 3 cycles, b*w*R^-1 mod q per lane
    mont_mul_lanes u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_vld  (accept),
        .i_a    (i_a),
        .i_b    (i_b),
        .i_w    (i_w),
        .o_vld  (mul_vld),
        .o_a    (mul_a),
        .o_prod (mul_prod)
    );

    // 1 cycle, a +/- product
    mod_add_sub_lanes u_addsub (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_vld  (mul_vld),
        .i_a    (mul_a),
        .i_prod (mul_prod),
        .o_vld  (res_vld),
        .o_ao   (res_ao),
        .o_bo   (res_bo)
    );

    // holds results under back-pressure and owns i_rdy
    out_buffer u_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wr     (res_vld),
        .i_ao     (res_ao),
        .i_bo     (res_bo),
        .i_accept (accept),
        .o_rdy    (o_rdy),
        .i_rdy    (i_rdy),
        .o_vld    (o_vld),
        .o_ao     (o_ao),
        .o_bo     (o_bo)
    );

endmodule

/* hw/out_buffer.sv */
`include "bfly_settings.svh"

module out_buffer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_wr,
    input  bfly_pkg::word_t i_ao,
    input  bfly_pkg::word_t i_bo,
    input  logic            i_accept,
    input  logic            o_rdy,
    output logic            i_rdy,
    output logic            o_vld,
    output bfly_pkg::word_t o_ao,
    output bfly_pkg::word_t o_bo
);
    import bfly_pkg::*;

    localparam int PTR_W = $clog2(`BFLY_BUF_DEPTH);
    localparam int CNT_W = $clog2(`BFLY_BUF_DEPTH + 1);

    word_t            mem_ao [`BFLY_BUF_DEPTH];
    word_t            mem_bo [`BFLY_BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] stored_cnt;   // entries sitting in the FIFO
    logic [CNT_W-1:0] flight_cnt;   // accepted, not yet written
    logic [CNT_W:0]   total;
    logic             pop;

    // circular pointers, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        if (p == PTR_W'(`BFLY_BUF_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign pop   = o_vld & o_rdy;
    assign total = stored_cnt + flight_cnt;

    // every word in flight already owns a slot, so the
    // pipeline can never write into a full FIFO
    assign i_rdy = total < (CNT_W+1)'(`BFLY_BUF_DEPTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            stored_cnt <= '0;
            flight_cnt <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            stored_cnt <= stored_cnt + CNT_W'(i_wr) - CNT_W'(pop);
            flight_cnt <= flight_cnt + CNT_W'(i_accept) - CNT_W'(i_wr);
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem_ao[wr_ptr] <= i_ao;
            mem_bo[wr_ptr] <= i_bo;
        end
    end

    // head entry is held until the sink takes it
    assign o_vld = stored_cnt != '0;
    assign o_ao  = mem_ao[rd_ptr];
    assign o_bo  = mem_bo[rd_ptr];

endmodule

/* hw/mod_add_sub_lanes.sv */
`include "bfly_settings.svh"

module mod_add_sub_lanes (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_vld,
    input  bfly_pkg::word_t i_a,
    input  bfly_pkg::word_t i_prod,
    output logic            o_vld,
    output bfly_pkg::word_t o_ao,
    output bfly_pkg::word_t o_bo
);
    import bfly_pkg::*;

    // both inputs below q, so one correction is enough
    function automatic coef_t add_mod(coef_t a, coef_t p);
        logic [`BFLY_COEF_W:0] s;   // one carry bit
        s = a + p;
        if (s >= (`BFLY_COEF_W+1)'(`BFLY_Q)) begin
            s = s - (`BFLY_COEF_W+1)'(`BFLY_Q);
        end
        return coef_t'(s);
    endfunction

    function automatic coef_t sub_mod(coef_t a, coef_t p);
        coef_t d;
        d = a - p;                  // wraps when a < p
        if (a < p) begin
            d = d + coef_t'(`BFLY_Q);
        end
        return d;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_vld <= 1'b0;
        end else begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `BFLY_LANES; l++) begin
            o_ao[l] <= add_mod(i_a[l], i_prod[l]);
            o_bo[l] <= sub_mod(i_a[l], i_prod[l]);
        end
    end

endmodule

/* hw/mont_mul_lanes.sv */
`include "bfly_settings.svh"

module mont_mul_lanes (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_vld,
    input  bfly_pkg::word_t i_a,
    input  bfly_pkg::word_t i_b,
    input  bfly_pkg::word_t i_w,
    output logic            o_vld,
    output bfly_pkg::word_t o_a,
    output bfly_pkg::word_t o_prod
);
    import bfly_pkg::*;

    logic [2:0] vld_pipe;
    word_t      a_pipe [3];
    prod_t      t_s1 [`BFLY_LANES];   // b*w
    prod_t      t_s2 [`BFLY_LANES];
    coef_t      m_s2 [`BFLY_LANES];   // reduction factor

    // (t + m*q) / R, then one conditional subtract
    // t < q^2 keeps the quotient below 2q
    function automatic coef_t mont_reduce(prod_t t, coef_t m);
        prod_t sum;
        prod_t u;
        sum = t + prod_t'(m) * prod_t'(`BFLY_Q);  // low half is zero by construction
        u   = sum >> `BFLY_COEF_W;
        if (u >= prod_t'(`BFLY_Q)) begin
            u = u - prod_t'(`BFLY_Q);
        end
        return coef_t'(u);
    endfunction

    // fixed latency, valid just shifts along
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[1:0], i_vld};
        end
    end

    // operand a travels beside the multiplier stages
    always_ff @(posedge clk) begin
        a_pipe[0] <= i_a;
        a_pipe[1] <= a_pipe[0];
        a_pipe[2] <= a_pipe[1];
    end

    // stage 1, full product
    always_ff @(posedge clk) begin
        for (int l = 0; l < `BFLY_LANES; l++) begin
            t_s1[l] <= prod_t'(i_b[l]) * prod_t'(i_w[l]);
        end
    end

    // stage 2
    // m = t * (-q^-1) mod R, only the low half of t matters
    always_ff @(posedge clk) begin
        for (int l = 0; l < `BFLY_LANES; l++) begin
            m_s2[l] <= t_s1[l][`BFLY_COEF_W-1:0] * coef_t'(`BFLY_QINV_NEG);
            t_s2[l] <= t_s1[l];
        end
    end

    // stage 3
    always_ff @(posedge clk) begin
        for (int l = 0; l < `BFLY_LANES; l++) begin
            o_prod[l] <= mont_reduce(t_s2[l], m_s2[l]);
        end
    end

    assign o_vld = vld_pipe[2];
    assign o_a   = a_pipe[2];

endmodule

/* hw/bfly_pkg.sv */
`include "bfly_settings.svh"

package bfly_pkg;

    // one coefficient, always kept below q on the ports
    typedef logic [`BFLY_COEF_W-1:0] coef_t;

    // lane 0 sits in the low 16 bits
    typedef coef_t [`BFLY_LANES-1:0] word_t;

    // full b*w product before reduction
    typedef logic [2*`BFLY_COEF_W-1:0] prod_t;

endpackage

/* include/bfly_settings.svh */
`ifndef BFLY_SETTINGS_SVH
`define BFLY_SETTINGS_SVH

// coefficient lanes packed in one 128-bit word
`define BFLY_LANES 8
`define BFLY_COEF_W 16

// prime modulus of the ring
`define BFLY_Q 12289

// -q^-1 mod 2^16, so q * this == -1 mod R
`define BFLY_QINV_NEG 12287

// result slots in the output FIFO, 2 or more
`define BFLY_BUF_DEPTH 8

`endif
